// ==== include/mips_pipe_settings.svh ====
`ifndef MIPS_PIPE_SETTINGS_SVH
`define MIPS_PIPE_SETTINGS_SVH

// Datapath and instruction word width
`define MIPS_XLEN 32

// Register index width, gives 32 architectural registers
`define MIPS_REG_ADDR_W 5

// Data RAM depth in words, must be a power of two
`define MIPS_DMEM_WORDS 64

// Address of the first fetch after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

// ==== source/mips_pipe_pkg.sv ====
`default_nettype none

`include "mips_pipe_settings.svh"

package mips_pipe_pkg;

    typedef logic [`MIPS_XLEN-1:0]       word_t;      // Data, address or instruction
    typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;  // Register index

    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,   // Function picked by funct field
        OP_ADDI  = 6'd8,
        OP_SLTI  = 6'd10,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL = 6'd0,
        FN_SRL = 6'd2,
        FN_ADD = 6'd32,
        FN_SUB = 6'd34,
        FN_AND = 6'd36,
        FN_OR  = 6'd37,
        FN_XOR = 6'd38,
        FN_NOR = 6'd39,
        FN_SLT = 6'd42
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLL, ALU_SRL
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG,  // Value read in decode
        FWD_ME,   // ALU result sitting in memory stage
        FWD_WB    // Value being written back
    } fwd_sel_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        alu_op_e   alu_op;
        logic      alu_src;    // B operand is the immediate
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dest;
        logic [4:0] shamt;
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm;        // Already extended
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        reg_addr_t dest;       // rt for SW, store source register
        word_t     alu_result; // Also the data address
        word_t     store_data;
    } ex_me_t;

    typedef struct packed {
        logic      valid;
        logic      mem_to_reg; // Load result goes to the register
        logic      reg_write;
        reg_addr_t dest;
        word_t     alu_result;
        word_t     load_data;
    } me_wb_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        word_t     data;
    } retire_t;

    typedef struct packed {
        logic  valid;
        word_t addr;  // Word index into the data RAM
        word_t data;
    } store_t;

endpackage

`default_nettype wire

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_pipe_settings.svh"

module fetch_stage
    import mips_pipe_pkg::*;
(
    input  logic   clock,
    input  logic   rst_n,
    input  logic   stall,      // Load-use hold from hazard unit
    output word_t  imem_addr,
    input  word_t  imem_data,  // Returned in the same cycle
    output if_id_t if_id
);

    word_t pc;

    assign imem_addr = pc;  // PC drives the instruction memory directly

    always_ff @(posedge clock) begin
        if (!stall) begin
            if_id.pc    <= pc;         // Payload follows the PC
            if_id.instr <= imem_data;
        end
        if (!rst_n) begin
            pc          <= `MIPS_RESET_PC;
            if_id.valid <= 1'b0;
        end else if (!stall) begin
            pc          <= pc + word_t'(4);  // Sequential fetch only
            if_id.valid <= 1'b1;             // Stays set once running
        end
    end

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_pipe_settings.svh"

module decode_stage
    import mips_pipe_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  logic      stall,
    input  if_id_t    if_id,
    output reg_addr_t rs,
    output reg_addr_t rt,
    output logic      rt_used,  // Instruction reads rt as a source
    input  word_t     rs_data,
    input  word_t     rt_data,
    output id_ex_t    id_ex
);

    opcode_e    opcode;
    funct_e     funct;
    reg_addr_t  rd;
    logic [4:0] shamt;
    logic [15:0] imm16;
    alu_op_e    alu_op;
    logic       alu_src, mem_read, mem_write, reg_write, sign_ext;
    reg_addr_t  dest;
    word_t      imm;

    assign opcode = opcode_e'(if_id.instr[31:26]);
    assign rs     = if_id.instr[25:21];
    assign rt     = if_id.instr[20:16];
    assign rd     = if_id.instr[15:11];
    assign shamt  = if_id.instr[10:6];
    assign funct  = funct_e'(if_id.instr[5:0]);
    assign imm16  = if_id.instr[15:0];
    assign imm    = {{(`MIPS_XLEN-16){imm16[15] & sign_ext}}, imm16};  // Sign or zero extend

    always_comb begin
        alu_op    = ALU_ADD;  // Defaults give a no-op
        alu_src   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        sign_ext  = 1'b1;
        rt_used   = 1'b0;
        dest      = rt;       // I-type writes rt
        case (opcode)
            OP_RTYPE: begin
                dest      = rd;
                rt_used   = 1'b1;
                reg_write = 1'b1;
                case (funct)
                    FN_ADD:  alu_op = ALU_ADD;
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    default: reg_write = 1'b0;  // Unknown funct
                endcase
            end
            OP_ADDI: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            OP_SLTI: begin
                alu_op    = ALU_SLT;
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            OP_ANDI, OP_ORI: begin
                alu_op    = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
                alu_src   = 1'b1;
                sign_ext  = 1'b0;  // Logical immediates are zero extended
                reg_write = 1'b1;
            end
            OP_LW: begin
                alu_src   = 1'b1;
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            OP_SW: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
                rt_used   = 1'b1;  // Store data source
            end
            default: ;             // Unknown opcode
        endcase
        if (dest == '0) begin
            reg_write = 1'b0;      // r0 is never written
        end
    end

    always_ff @(posedge clock) begin
        id_ex.alu_op  <= alu_op;
        id_ex.alu_src <= alu_src;
        id_ex.rs      <= rs;
        id_ex.rt      <= rt;
        id_ex.dest    <= dest;
        id_ex.shamt   <= shamt;
        id_ex.rs_data <= rs_data;
        id_ex.rt_data <= rt_data;
        id_ex.imm     <= imm;
        if (!rst_n || stall) begin
            id_ex.valid     <= 1'b0;  // Bubble
            id_ex.mem_read  <= 1'b0;
            id_ex.mem_write <= 1'b0;
            id_ex.reg_write <= 1'b0;
        end else begin
            id_ex.valid     <= if_id.valid;
            id_ex.mem_read  <= if_id.valid && mem_read;  // Controls qualified once here
            id_ex.mem_write <= if_id.valid && mem_write;
            id_ex.reg_write <= if_id.valid && reg_write;
        end
    end

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_pipe_settings.svh"

module register_file
    import mips_pipe_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    output word_t     rs_data,
    output word_t     rt_data,
    input  logic      wb_we,
    input  reg_addr_t wb_dest,
    input  word_t     wb_data
);

    localparam int NUM_REGS = 2 ** `MIPS_REG_ADDR_W;

    word_t regs [1:NUM_REGS-1];  // No storage behind r0

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_dest != '0) begin
            regs[wb_dest] <= wb_data;
        end
    end

    function automatic word_t read_port(reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wb_we && wb_dest == addr) begin
            value = wb_data;      // Write-through, decode sees this cycle's write-back
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs_data = read_port(rs);
        rt_data = read_port(rt);
    end

    // Decode must have dropped reg_write for an r0 destination
    a_no_r0_write: assert property (@(posedge clock) disable iff (!rst_n)
        wb_we |-> wb_dest != '0)
        else $error("write-back targets r0");

endmodule

`default_nettype wire

// ==== source/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
    import mips_pipe_pkg::*;
(
    input  logic      clock,      // Assertion sampling only
    input  logic      rst_n,
    input  reg_addr_t rs,         // Decode sources
    input  reg_addr_t rt,
    input  logic      rt_used,
    input  id_ex_t    id_ex,
    input  ex_me_t    ex_me,
    input  me_wb_t    me_wb,
    output logic      stall,
    output fwd_sel_e  fwd_a,
    output fwd_sel_e  fwd_b,
    output logic      store_fwd
);

    logic me_we, wb_we, load_in_ex;

    assign me_we      = ex_me.valid && ex_me.reg_write;
    assign wb_we      = me_wb.valid && me_wb.reg_write;
    assign load_in_ex = id_ex.valid && id_ex.mem_read && id_ex.dest != '0;

    function automatic logic hit(logic we, reg_addr_t dest, reg_addr_t src);
        return we && dest != '0 && dest == src;
    endfunction

    function automatic fwd_sel_e pick(reg_addr_t src);
        fwd_sel_e sel;
        if (hit(me_we, ex_me.dest, src)) begin
            sel = FWD_ME;   // Youngest producer wins
        end else if (hit(wb_we, me_wb.dest, src)) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_REG;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a     = pick(id_ex.rs);
        fwd_b     = pick(id_ex.rt);  // Also feeds store data
        store_fwd = ex_me.valid && ex_me.mem_write && hit(wb_we, me_wb.dest, ex_me.dest);
        stall     = load_in_ex &&
                    (id_ex.dest == rs || (rt_used && id_ex.dest == rt));  // Load-use
    end

    // The bubble sent on a stall must clear the load-use case next cycle
    a_single_stall: assert property (@(posedge clock) disable iff (!rst_n)
        stall |=> !stall)
        else $error("stall held for two cycles");

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import mips_pipe_pkg::*;
(
    input  logic     clock,
    input  logic     rst_n,
    input  id_ex_t   id_ex,
    input  fwd_sel_e fwd_a,
    input  fwd_sel_e fwd_b,
    input  word_t    wb_data,  // Write-back forward value
    output ex_me_t   ex_me
);

    word_t op_a, op_b, rt_fwd, alu_result;

    function automatic word_t pick(fwd_sel_e sel, word_t reg_value);
        word_t value;
        case (sel)
            FWD_ME:  value = ex_me.alu_result;  // Own registered result
            FWD_WB:  value = wb_data;
            default: value = reg_value;
        endcase
        return value;
    endfunction

    always_comb begin
        op_a   = pick(fwd_a, id_ex.rs_data);
        rt_fwd = pick(fwd_b, id_ex.rt_data);
        op_b   = id_ex.alu_src ? id_ex.imm : rt_fwd;
        case (id_ex.alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_NOR: alu_result = ~(op_a | op_b);
            ALU_SLT: alu_result = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLL: alu_result = op_b << id_ex.shamt;  // Shifts act on rt
            ALU_SRL: alu_result = op_b >> id_ex.shamt;
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        ex_me.dest       <= id_ex.dest;
        ex_me.alu_result <= alu_result;
        ex_me.store_data <= rt_fwd;    // Forwarded rt for SW
        if (!rst_n) begin
            ex_me.valid     <= 1'b0;
            ex_me.mem_read  <= 1'b0;
            ex_me.mem_write <= 1'b0;
            ex_me.reg_write <= 1'b0;
        end else begin
            ex_me.valid     <= id_ex.valid;
            ex_me.mem_read  <= id_ex.mem_read;
            ex_me.mem_write <= id_ex.mem_write;
            ex_me.reg_write <= id_ex.reg_write;
        end
    end

endmodule

`default_nettype wire

// ==== source/memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_pipe_settings.svh"

module memory_stage
    import mips_pipe_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  ex_me_t    ex_me,
    input  logic      store_fwd,  // Store data comes from write-back
    output me_wb_t    me_wb,      // To hazard unit
    output logic      wb_we,
    output reg_addr_t wb_dest,
    output word_t     wb_data,
    output retire_t   retire,
    output store_t    store
);

    localparam int DMEM_AW = $clog2(`MIPS_DMEM_WORDS);

    word_t              dmem [`MIPS_DMEM_WORDS];
    logic [DMEM_AW-1:0] dmem_idx;
    logic               mem_we;
    word_t              store_data;

    assign dmem_idx   = ex_me.alu_result[DMEM_AW+1:2];  // Word address, wraps at depth
    assign mem_we     = ex_me.valid && ex_me.mem_write;
    assign store_data = store_fwd ? wb_data : ex_me.store_data;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `MIPS_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_we) begin
            dmem[dmem_idx] <= store_data;  // Write at end of memory cycle
        end
    end

    always_ff @(posedge clock) begin
        me_wb.mem_to_reg <= ex_me.mem_read;
        me_wb.dest       <= ex_me.dest;
        me_wb.alu_result <= ex_me.alu_result;
        me_wb.load_data  <= dmem[dmem_idx];  // Combinational read
        if (!rst_n) begin
            me_wb.valid     <= 1'b0;
            me_wb.reg_write <= 1'b0;
        end else begin
            me_wb.valid     <= ex_me.valid;
            me_wb.reg_write <= ex_me.reg_write;
        end
    end

    assign wb_we   = me_wb.valid && me_wb.reg_write;
    assign wb_dest = me_wb.dest;
    assign wb_data = me_wb.mem_to_reg ? me_wb.load_data : me_wb.alu_result;

    assign retire = '{valid: wb_we, dest: wb_dest, data: wb_data};
    assign store  = '{valid: mem_we, addr: word_t'(dmem_idx), data: store_data};

    // Decode never sets both memory controls for one instruction
    a_rd_wr_excl: assert property (@(posedge clock) disable iff (!rst_n)
        !(ex_me.mem_read && ex_me.mem_write))
        else $error("load and store in memory stage together");

endmodule

`default_nettype wire

// ==== source/mips_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_pipe
    import mips_pipe_pkg::*;
(
    input  logic    clock,
    input  logic    rst_n,
    output word_t   imem_addr,
    input  word_t   imem_data,
    output retire_t retire,
    output store_t  store
);

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_me_t    ex_me;
    me_wb_t    me_wb;
    reg_addr_t rs, rt, wb_dest;
    word_t     rs_data, rt_data, wb_data;
    logic      rt_used, stall, store_fwd, wb_we;
    fwd_sel_e  fwd_a, fwd_b;

    fetch_stage u_fetch (
        .clock     (clock),
        .rst_n     (rst_n),
        .stall     (stall),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .if_id     (if_id)
    );

    decode_stage u_decode (
        .clock   (clock),
        .rst_n   (rst_n),
        .stall   (stall),
        .if_id   (if_id),
        .rs      (rs),
        .rt      (rt),
        .rt_used (rt_used),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .id_ex   (id_ex)
    );

    register_file u_regs (
        .clock   (clock),
        .rst_n   (rst_n),
        .rs      (rs),
        .rt      (rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb_we   (wb_we),
        .wb_dest (wb_dest),
        .wb_data (wb_data)
    );

    hazard_unit u_hazard (
        .clock     (clock),
        .rst_n     (rst_n),
        .rs        (rs),
        .rt        (rt),
        .rt_used   (rt_used),
        .id_ex     (id_ex),
        .ex_me     (ex_me),
        .me_wb     (me_wb),
        .stall     (stall),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .store_fwd (store_fwd)
    );

    execute_stage u_execute (
        .clock   (clock),
        .rst_n   (rst_n),
        .id_ex   (id_ex),
        .fwd_a   (fwd_a),
        .fwd_b   (fwd_b),
        .wb_data (wb_data),
        .ex_me   (ex_me)
    );

    memory_stage u_memory (
        .clock     (clock),
        .rst_n     (rst_n),
        .ex_me     (ex_me),
        .store_fwd (store_fwd),
        .me_wb     (me_wb),
        .wb_we     (wb_we),
        .wb_dest   (wb_dest),
        .wb_data   (wb_data),
        .retire    (retire),
        .store     (store)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2.0) clock = ~clock;  // 4 ns period
    end

    initial begin
        rst_n = 1'b0;                             // Held low from time zero
        repeat (RESET_CYCLES) @(negedge clock);
        rst_n = 1'b1;                             // Released on a falling edge
    end

endmodule

`default_nettype wire

// ==== testbench/tb_mips_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_pipe_settings.svh"

module tb_mips_pipe
    import mips_pipe_pkg::*;
();

    localparam int PROG_LEN     = 200;
    localparam int DIRECTED_LEN = 8;                 // Fixed hazard cases ahead of random code
    localparam int CYCLE_LIMIT  = 2 * PROG_LEN + 20;

    logic    clock, rst_n;
    word_t   imem_addr;
    word_t   imem_data = '0;
    retire_t retire;
    store_t  store;

    word_t       prog_words [PROG_LEN];
    logic [31:0] lfsr_state;
    retire_t     exp_retire [$];                     // Expected in program order
    store_t      exp_store [$];
    int          kind_seen [16];
    int          alu_deps = 0, load_uses = 0, store_deps = 0;
    int          loads_hit = 0, loads_fresh = 0, r0_writes = 0;
    int          error_count = 0, retires_checked = 0, stores_checked = 0;
    int          since_reset = 0;
    logic        run_q = 1'b0;

    tb_clock_gen u_clock_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    mips_pipe u_mips_pipe (
        .clock     (clock),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .retire    (retire),
        .store     (store)
    );

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);        // One step per bit
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic word_t enc_r(funct_e fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt,
                                    logic [4:0] sh);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t enc_i(opcode_e op, reg_addr_t rt, reg_addr_t rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic funct_e funct_for(int k);
        case (k)
            0: return FN_ADD;
            1: return FN_SUB;
            2: return FN_AND;
            3: return FN_OR;
            4: return FN_XOR;
            5: return FN_NOR;
            6: return FN_SLT;
            7: return FN_SLL;
            default: return FN_SRL;
        endcase
    endfunction

    function automatic void make_program();
        int          kind;
        reg_addr_t   rs, rt, rd;
        logic [4:0]  sh;
        logic [15:0] imm, off;
        lfsr_state = 32'd79467;
        prog_words[0] = enc_i(OP_ADDI, 5'd1, 5'd0, 16'h8234);     // Negative immediate
        prog_words[1] = enc_i(OP_SW, 5'd1, 5'd0, 16'h0010);       // Data from ALU just ahead
        prog_words[2] = enc_i(OP_LW, 5'd2, 5'd0, 16'h0010);       // Reads the word just stored
        prog_words[3] = enc_r(FN_ADD, 5'd3, 5'd2, 5'd1, 5'd0);    // Load-use on r2
        prog_words[4] = enc_i(OP_LW, 5'd4, 5'd0, 16'h0020);       // Word never stored reads zero
        prog_words[5] = enc_i(OP_SW, 5'd4, 5'd0, 16'h0024);       // Data from load just ahead
        prog_words[6] = enc_r(FN_OR, 5'd0, 5'd1, 5'd1, 5'd0);     // Write to r0 is dropped
        prog_words[7] = enc_r(FN_SUB, 5'd5, 5'd3, 5'd0, 5'd0);    // r0 as a source
        for (int i = DIRECTED_LEN; i < PROG_LEN; i++) begin
            kind = int'(take_bits(4));
            rs   = reg_addr_t'(take_bits(3));                 // r0-r7 keeps hazards frequent
            rt   = reg_addr_t'(take_bits(3));
            rd   = reg_addr_t'(take_bits(3));
            sh   = 5'(take_bits(5));
            imm  = 16'(take_bits(16));
            off  = 16'(take_bits(6) << 2);                   // Word aligned and below 256
            kind_seen[kind]++;
            case (kind)
                9:       prog_words[i] = enc_i(OP_ADDI, rt, rs, imm);
                10:      prog_words[i] = enc_i(OP_SLTI, rt, rs, imm);
                11:      prog_words[i] = enc_i(OP_ANDI, rt, rs, imm);
                12:      prog_words[i] = enc_i(OP_ORI, rt, rs, imm);
                13, 14:  prog_words[i] = enc_i(OP_LW, rt, 5'd0, off);  // Base is r0
                15:      prog_words[i] = enc_i(OP_SW, rt, 5'd0, off);
                default: prog_words[i] = enc_r(funct_for(kind), rd, rs, rt, sh);
            endcase
        end
    endfunction

    // Sequential ISA model that runs one instruction at a time
    function automatic void build_reference();
        word_t     regs [32];
        word_t     ram [`MIPS_DMEM_WORDS];
        logic      stored [`MIPS_DMEM_WORDS];
        word_t     w, a, b, simm, zimm, value;
        reg_addr_t rs, rt, dest, prev_dest;
        opcode_e   op;
        int        idx;
        logic      writes, reads_rt, prev_load;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int m = 0; m < `MIPS_DMEM_WORDS; m++) begin
            ram[m]    = '0;
            stored[m] = 1'b0;
        end
        prev_dest = '0;
        prev_load = 1'b0;
        for (int i = 0; i < PROG_LEN; i++) begin
            w        = prog_words[i];
            op       = opcode_e'(w[31:26]);
            rs       = w[25:21];
            rt       = w[20:16];
            a        = regs[rs];
            b        = regs[rt];
            simm     = {{16{w[15]}}, w[15:0]};
            zimm     = {16'h0000, w[15:0]};
            idx      = int'(((a + simm) >> 2) % word_t'(`MIPS_DMEM_WORDS));  // Word index
            dest     = rt;
            writes   = 1'b1;
            reads_rt = (op == OP_RTYPE) || (op == OP_SW);
            value    = '0;
            case (op)
                OP_RTYPE: begin
                    dest = w[15:11];
                    case (funct_e'(w[5:0]))
                        FN_ADD:  value = a + b;
                        FN_SUB:  value = a - b;
                        FN_AND:  value = a & b;
                        FN_OR:   value = a | b;
                        FN_XOR:  value = a ^ b;
                        FN_NOR:  value = ~(a | b);
                        FN_SLT:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SLL:  value = b << w[10:6];
                        FN_SRL:  value = b >> w[10:6];
                        default: writes = 1'b0;
                    endcase
                end
                OP_ADDI: value = a + simm;
                OP_SLTI: value = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
                OP_ANDI: value = a & zimm;
                OP_ORI:  value = a | zimm;
                OP_LW: begin
                    value = ram[idx];
                    if (stored[idx]) loads_hit++;
                    else loads_fresh++;
                end
                OP_SW: begin
                    writes      = 1'b0;
                    ram[idx]    = b;
                    stored[idx] = 1'b1;
                    exp_store.push_back(store_t'{valid: 1'b1, addr: word_t'(idx), data: b});
                    if (rt != '0 && rt == prev_dest) store_deps++;
                end
                default: writes = 1'b0;
            endcase
            if (prev_dest != '0 && (rs == prev_dest || (reads_rt && rt == prev_dest))) begin
                if (prev_load) load_uses++;
                else alu_deps++;
            end
            if (writes && dest == '0) r0_writes++;
            if (writes && dest != '0) begin
                regs[dest] = value;
                exp_retire.push_back(retire_t'{valid: 1'b1, dest: dest, data: value});
            end
            prev_dest = writes ? dest : '0;
            prev_load = (op == OP_LW);
        end
    endfunction

    function automatic word_t fetch_word(word_t addr);
        word_t idx;
        idx = addr >> 2;
        return (idx < word_t'(PROG_LEN)) ? prog_words[int'(idx)] : '0;  // Past the end is a no-op
    endfunction

    task automatic check_retire(retire_t got, retire_t exp);
        if (got.dest !== exp.dest) begin
            $display("ERROR %0t retire.dest expected %0d got %0d", $time, exp.dest, got.dest);
            error_count++;
        end
        if (got.data !== exp.data) begin
            $display("ERROR %0t retire.data expected %h got %h", $time, exp.data, got.data);
            error_count++;
        end
        retires_checked++;
    endtask

    task automatic check_store(store_t got, store_t exp);
        if (got.addr !== exp.addr) begin
            $display("ERROR %0t store.addr expected %0d got %0d", $time, exp.addr, got.addr);
            error_count++;
        end
        if (got.data !== exp.data) begin
            $display("ERROR %0t store.data expected %h got %h", $time, exp.data, got.data);
            error_count++;
        end
        stores_checked++;
    endtask

    task automatic require_seen(int count, string what);
        if (count == 0) begin
            $display("Coverage gap, the program holds no %s", what);
            error_count++;
        end
    endtask

    always @(negedge clock) begin
        imem_data <= fetch_word(imem_addr);  // PC settled since the rising edge
    end

    always @(posedge clock) begin
        run_q <= rst_n;                      // Reset seen by the core this cycle
    end

    // Compare process samples the outputs mid-cycle
    always @(negedge clock) begin
        if (!run_q) begin
            since_reset = 0;
        end else begin
            since_reset++;
            if (retire.valid) begin
                if (since_reset < 4) begin
                    $display("Retire reported at %0t, before any instruction could finish", $time);
                    error_count++;
                end
                if (retire.dest == '0) begin
                    $display("Retire at %0t reports a write to r0", $time);
                    error_count++;
                end
                if (exp_retire.size() == 0) begin
                    $display("Unexpected retire of r%0d at %0t", retire.dest, $time);
                    error_count++;
                end else begin
                    check_retire(retire, exp_retire.pop_front());
                end
            end
            if (store.valid) begin
                if (since_reset < 3) begin
                    $display("Store reported at %0t, before any store could reach memory", $time);
                    error_count++;
                end
                if (exp_store.size() == 0) begin
                    $display("Unexpected store to word %0d at %0t", store.addr, $time);
                    error_count++;
                end else begin
                    check_store(store, exp_store.pop_front());
                end
            end
        end
    end

    initial begin
        int   cycles;
        logic timed_out;
        make_program();
        build_reference();
        @(posedge clock);
        while (rst_n !== 1'b1) @(posedge clock);
        cycles = 0;
        while ((exp_retire.size() > 0 || exp_store.size() > 0) && cycles < CYCLE_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        timed_out = (exp_retire.size() > 0 || exp_store.size() > 0);
        if (timed_out) begin
            $display("Timeout after %0d cycles, %0d retires and %0d stores never appeared",
                     cycles, exp_retire.size(), exp_store.size());
            error_count++;
        end else begin
            repeat (10) @(posedge clock);    // Catch outputs beyond the program
        end
        for (int k = 0; k < 16; k++) begin
            require_seen(kind_seen[k], $sformatf("instruction kind %0d", k));
        end
        require_seen(alu_deps, "ALU result used by the next instruction");
        require_seen(load_uses, "load result used by the next instruction");
        require_seen(store_deps, "store of a register written just ahead");
        require_seen(loads_hit, "load from a stored word");
        require_seen(loads_fresh, "load from a word never stored");
        require_seen(r0_writes, "write to r0");
        $display("Checked %0d retires and %0d stores, %0d errors",
                 retires_checked, stores_checked, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mips_pipe.f ====
+incdir+include
source/mips_pipe_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/register_file.sv
source/hazard_unit.sv
source/execute_stage.sv
source/memory_stage.sv
source/mips_pipe.sv
testbench/tb_clock_gen.sv
testbench/tb_mips_pipe.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the mips_pipe testbench with Verilator, judge the run from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mips_pipe -f mips_pipe.f \
    --Mdir obj_dir -o tb_mips_pipe \
    && ./obj_dir/tb_mips_pipe > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "^Done: no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
